// ==== rtl/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  // opcodes as sent by the esp
  typedef enum logic [7:0] {
    get_cookie     = 8'd0,
    dbus_read      = 8'd3,
    dbus_write     = 8'd4,
    data_ready     = 8'd5,
    get_version    = 8'd15,
    abus_read      = 8'd18,
    set_led        = 8'd26,
    get_config     = 8'd27,
    set_esp_status = 8'd32
  } cmd_e;

  localparam logic [7:0] cookie        = 8'hAF;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  typedef struct packed {
    logic [4:0] rsvd;
    logic       blue;
    logic       green;
    logic       red;
  } led_cfg_t;

  typedef struct packed {
    logic [3:0] rsvd;
    logic       sd_mounted;
    logic       smb_mounted;
    logic       wifi_up;
    logic       esp_ready;
  } esp_status_t;

  // first parameter byte, meaning depends on opcode
  typedef union packed {
    led_cfg_t    led;
    esp_status_t status;
  } param_u;

  typedef struct packed {
    logic   valid;
    cmd_e   opcode;
    param_u param;
  } cmd_action_t;

  function automatic logic is_known_cmd(logic [7:0] op);
    case (op)
      get_cookie, dbus_read, dbus_write, data_ready, get_version,
      abus_read, set_led, get_config, set_esp_status: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // parameter bytes following the opcode
  function automatic logic [2:0] param_count(cmd_e op);
    case (op)
      dbus_write, set_led, set_esp_status: return 3'd1;
      default: return 3'd0;
    endcase
  endfunction

endpackage

// ==== rtl/trs_bus_pkg.sv ====
package trs_bus_pkg;

  // cpu bus with strobes already turned active high
  typedef struct packed {
    logic [15:0] addr;
    logic        rd;
    logic        wr;
    logic        in;
    logic        out;
  } trs_bus_t;

  localparam logic [7:0]  trs_io_port     = 8'h1F;
  localparam logic [3:0]  frehd_base      = 4'hC;     // C0h-CFh
  localparam logic [15:0] irq_status_base = 16'h37E0; // 37E0h-37E3h

  // status code presented to the esp
  typedef enum logic [3:0] {
    trs_io_in  = 4'h0,
    trs_io_out = 4'h1,
    frehd_in   = 4'h2,
    frehd_out  = 4'h3,
    idle       = 4'hF
  } esp_s_e;

  localparam int esp_req_cycles     = 50;
  localparam int irq_period_default = 2_100_000; // 25 ms at 84 MHz

  typedef struct packed {
    logic trs_io_in;
    logic trs_io_out;
    logic frehd_in;
    logic frehd_out;
    logic irq_rd;
  } port_sel_t;

endpackage

// ==== rtl/spi_byte_link.sv ====
`timescale 1ns/1ns

module spi_byte_link (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       cs,
  input  logic       mosi,
  input  logic [7:0] reply_byte,
  output logic [7:0] byte_in,
  output logic       byte_valid,
  output logic       miso
);

  logic [2:0] sck_sync;  // two sync flops plus edge history
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign cs_active = ~cs_sync[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      cs_sync   <= 2'b11;  // deselected
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  // mode 0, msb first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      rx_shift   <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_shift <= {rx_shift[6:0], mosi_sync[1]};
        if (bit_cnt == 3'd7) byte_valid <= 1'b1;
      end
    end
  end

  // reload between bytes, shift on falling edges inside a byte
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (bit_cnt == 3'd0) begin
      tx_shift <= reply_byte;
    end else if (sck_fall) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign byte_in = rx_shift;
  assign miso    = cs_active & tx_shift[7];

  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    byte_valid |=> !byte_valid);

endmodule

// ==== rtl/trs_port_decoder.sv ====
`timescale 1ns/1ns

module trs_port_decoder (
  input  logic                   clk,
  input  logic                   rst_n,
  input  trs_bus_pkg::trs_bus_t  bus,
  output trs_bus_pkg::port_sel_t sel,
  output logic                   access,
  output trs_bus_pkg::esp_s_e    esp_s
);

  import trs_bus_pkg::*;

  logic       strobe_any;
  logic [2:0] strobe_sync;
  logic       port_1f;
  logic       port_frehd;

  assign strobe_any = bus.rd | bus.wr | bus.in | bus.out;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_sync <= '0;
    end else begin
      strobe_sync <= {strobe_sync[1:0], strobe_any};
    end
  end

  assign access = strobe_sync[1] & ~strobe_sync[2];  // one cycle per bus cycle

  assign port_1f    = bus.addr[7:0] == trs_io_port;
  assign port_frehd = bus.addr[7:4] == frehd_base;

  assign sel.trs_io_in  = port_1f & bus.in;
  assign sel.trs_io_out = port_1f & bus.out;
  assign sel.frehd_in   = port_frehd & bus.in;
  assign sel.frehd_out  = port_frehd & bus.out;
  // memory read of the fdc irq status
  assign sel.irq_rd     = (bus.addr[15:2] == irq_status_base[15:2]) & bus.rd;

  always_comb begin
    esp_s = idle;
    if (sel.trs_io_in)       esp_s = trs_io_in;
    else if (sel.trs_io_out) esp_s = trs_io_out;
    else if (sel.frehd_in)   esp_s = frehd_in;
    else if (sel.frehd_out)  esp_s = frehd_out;
  end

  // the esp can only serve one request type per bus cycle
  a_one_esp_sel: assert property (@(posedge clk) disable iff (!rst_n)
    access |-> $onehot0({sel.trs_io_in, sel.trs_io_out, sel.frehd_in, sel.frehd_out}));

endmodule

// ==== rtl/cmd_parser.sv ====
`timescale 1ns/1ns

module cmd_parser (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [7:0]               byte_in,
  input  logic                     byte_valid,
  output spi_cmd_pkg::cmd_action_t action
);

  import spi_cmd_pkg::*;

  typedef enum logic {
    idle,
    collect
  } state_e;

  state_e     state;
  cmd_e       op_in;
  cmd_e       opcode_q;
  logic [2:0] left;     // parameter bytes still expected
  logic [7:0] first_q;

  assign op_in = cmd_e'(byte_in);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= idle;
      opcode_q <= get_cookie;
      left     <= '0;
      first_q  <= '0;
      action   <= '0;
    end else begin
      action.valid <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            // unknown opcodes are dropped here
            if (is_known_cmd(byte_in)) begin
              opcode_q <= op_in;
              left     <= param_count(op_in);
              if (param_count(op_in) == 3'd0) begin
                action <= '{valid: 1'b1, opcode: op_in, param: '0};
              end else begin
                state <= collect;
              end
            end
          end
          collect: begin
            if (left == param_count(opcode_q)) first_q <= byte_in;
            if (left == 3'd1) begin
              action <= '{valid: 1'b1,
                          opcode: opcode_q,
                          param: (left == param_count(opcode_q)) ? byte_in : first_q};
              state  <= idle;
            end else begin
              left <= left - 3'd1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  a_action_after_byte: assert property (@(posedge clk) disable iff (!rst_n)
    action.valid |-> $past(byte_valid));

endmodule

// ==== rtl/cmd_exec.sv ====
`timescale 1ns/1ns

module cmd_exec (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_cmd_pkg::cmd_action_t action,
  input  trs_bus_pkg::trs_bus_t    bus,
  input  logic [7:0]               d_in,
  input  logic [3:0]               conf,
  input  logic                     ready_clear,
  output logic [7:0]               reply_byte,
  output logic [7:0]               trs_data,
  output logic                     data_ready,
  output spi_cmd_pkg::led_cfg_t    led_rgb,
  output logic                     esp_ready
);

  import spi_cmd_pkg::*;

  esp_status_t esp_status;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reply_byte <= '0;
      trs_data   <= '0;
      led_rgb    <= '0;
      esp_status <= '0;
    end else if (action.valid) begin
      case (action.opcode)
        get_cookie:     reply_byte <= cookie;
        get_version:    reply_byte <= {version_major, version_minor};
        get_config:     reply_byte <= {4'b0000, ~conf};  // dip switches are active low
        dbus_read:      reply_byte <= d_in;
        abus_read:      reply_byte <= bus.addr[7:0];
        dbus_write:     trs_data   <= action.param;
        set_led:        led_rgb    <= action.param.led;
        set_esp_status: esp_status <= action.param.status;
        default: ;
      endcase
    end
  end

  // cpu access to 1Fh wins over a new data_ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_ready <= 1'b0;
    end else if (ready_clear) begin
      data_ready <= 1'b0;
    end else if (action.valid && action.opcode == spi_cmd_pkg::data_ready) begin
      data_ready <= 1'b1;
    end
  end

  assign esp_ready = esp_status.esp_ready;

endmodule

// ==== rtl/esp_handshake.sv ====
`timescale 1ns/1ns

module esp_handshake (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   access,
  input  trs_bus_pkg::port_sel_t sel,
  input  logic                   esp_done,
  output logic                   esp_req,
  output logic                   wait_out,
  output logic                   esp_sel
);

  import trs_bus_pkg::*;

  logic [$clog2(esp_req_cycles+1)-1:0] req_cnt;
  logic [2:0] done_sync;
  logic       done_rise;
  logic       esp_hit;

  assign esp_sel   = sel.trs_io_in | sel.trs_io_out | sel.frehd_in | sel.frehd_out;
  assign esp_hit   = access & esp_sel;
  assign done_rise = done_sync[1] & ~done_sync[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_cnt   <= '0;
      wait_out  <= 1'b0;
      done_sync <= '0;
    end else begin
      done_sync <= {done_sync[1:0], esp_done};
      if (esp_hit) req_cnt <= $bits(req_cnt)'(esp_req_cycles);
      else if (req_cnt != '0) req_cnt <= req_cnt - 1'b1;
      // hold the cpu until the esp has answered
      if (esp_hit) wait_out <= 1'b1;
      else if (done_rise) wait_out <= 1'b0;
    end
  end

  assign esp_req = req_cnt != '0;

  a_req_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    esp_req |-> wait_out);

endmodule

// ==== rtl/bus_responder.sv ====
`timescale 1ns/1ns

module bus_responder #(
  parameter int irq_period = trs_bus_pkg::irq_period_default
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   access,
  input  trs_bus_pkg::trs_bus_t  bus,
  input  trs_bus_pkg::port_sel_t sel,
  input  logic [7:0]             trs_data,
  input  logic                   data_ready,
  output logic [7:0]             d_out,
  output logic                   dbus_en,
  output logic                   dbus_dir,
  output logic                   irq,
  output logic                   ready_clear
);

  logic [$clog2(irq_period)-1:0] irq_cnt;
  logic       irq_tick;
  logic [7:0] irq_data;
  logic       esp_rd;

  assign irq_tick = irq_cnt == $bits(irq_cnt)'(irq_period - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_cnt <= '0;
    end else if (irq_tick) begin
      irq_cnt <= '0;
    end else begin
      irq_cnt <= irq_cnt + 1'b1;
    end
  end

  // status read clears INT, also when the timer fires in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq      <= 1'b0;
      irq_data <= '0;
    end else if (access && sel.irq_rd) begin
      irq      <= 1'b0;
      irq_data <= {irq, 1'b0, ~data_ready, 5'b00000};
    end else if (irq_tick) begin
      irq <= 1'b1;
    end
  end

  assign ready_clear = access & (sel.trs_io_in | sel.trs_io_out);
  assign esp_rd      = sel.trs_io_in | sel.frehd_in;  // byte from the esp

  always_comb begin
    d_out = '0;
    if (bus.rd || bus.in) begin
      if (esp_rd)          d_out = trs_data;
      else if (sel.irq_rd) d_out = irq_data;
    end
  end

  // transceiver enable, active low
  assign dbus_en  = ~(bus.wr | bus.out | esp_rd | sel.irq_rd);
  assign dbus_dir = ~(bus.rd | bus.in);  // low drives toward the cpu

endmodule

// ==== rtl/trs_io_top.sv ====
`timescale 1ns/1ns

module trs_io_top #(
  parameter int irq_period = trs_bus_pkg::irq_period_default
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [15:0]         a,
  input  logic                rd_n,
  input  logic                wr_n,
  input  logic                in_n,
  input  logic                out_n,
  input  logic [7:0]          d_in,
  output logic [7:0]          d_out,
  output logic                dbus_en,
  output logic                dbus_dir,
  input  logic                cs,
  input  logic                sck,
  input  logic                mosi,
  output logic                miso,
  output trs_bus_pkg::esp_s_e esp_s,
  output logic                esp_req,
  input  logic                esp_done,
  output logic                int_out,
  output logic                wait_out,
  input  logic [3:0]          conf,
  output logic [3:0]          led,
  output logic                led_red,
  output logic                led_green,
  output logic                led_blue
);

  import trs_bus_pkg::*;
  import spi_cmd_pkg::*;

  trs_bus_t    bus;
  port_sel_t   sel;
  cmd_action_t action;
  led_cfg_t    led_rgb;
  logic        access;
  logic [7:0]  byte_in;
  logic        byte_valid;
  logic [7:0]  reply_byte;
  logic [7:0]  trs_data;
  logic        data_ready;
  logic        ready_clear;
  logic        esp_ready;
  logic        esp_sel;

  assign bus = '{addr: a, rd: ~rd_n, wr: ~wr_n, in: ~in_n, out: ~out_n};

  trs_port_decoder u_dec (
    .clk(clk), .rst_n(rst_n), .bus(bus), .sel(sel), .access(access), .esp_s(esp_s)
  );

  spi_byte_link u_link (
    .clk(clk), .rst_n(rst_n), .sck(sck), .cs(cs), .mosi(mosi), .reply_byte(reply_byte),
    .byte_in(byte_in), .byte_valid(byte_valid), .miso(miso)
  );

  cmd_parser u_parser (
    .clk(clk), .rst_n(rst_n), .byte_in(byte_in), .byte_valid(byte_valid), .action(action)
  );

  cmd_exec u_exec (
    .clk(clk), .rst_n(rst_n), .action(action), .bus(bus), .d_in(d_in), .conf(conf),
    .ready_clear(ready_clear), .reply_byte(reply_byte), .trs_data(trs_data),
    .data_ready(data_ready), .led_rgb(led_rgb), .esp_ready(esp_ready)
  );

  esp_handshake u_hs (
    .clk(clk), .rst_n(rst_n), .access(access), .sel(sel), .esp_done(esp_done),
    .esp_req(esp_req), .wait_out(wait_out), .esp_sel(esp_sel)
  );

  bus_responder #(.irq_period(irq_period)) u_resp (
    .clk(clk), .rst_n(rst_n), .access(access), .bus(bus), .sel(sel), .trs_data(trs_data),
    .data_ready(data_ready), .d_out(d_out), .dbus_en(dbus_en), .dbus_dir(dbus_dir),
    .irq(int_out), .ready_clear(ready_clear)
  );

  assign led       = {esp_ready, data_ready, esp_sel, wait_out};
  assign led_red   = led_rgb.red;
  assign led_green = led_rgb.green;
  assign led_blue  = led_rgb.blue;

endmodule

// ==== dv/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic report_error(input string msg);
  errors++;
  $display("%s", msg);
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic check_esp_s(input esp_s_e got, input esp_s_e exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED esp_s: got %h, expected %h", got, exp);
  end
endtask

// rgb in bits 2..0, esp_ready in bit 0 of the status byte
task automatic check_leds(input logic [7:0] lp, input logic [7:0] sp);
  check_bit("led_red", led_red, lp[0]);
  check_bit("led_green", led_green, lp[1]);
  check_bit("led_blue", led_blue, lp[2]);
  check_bit("led esp_ready", led[3], sp[0]);
endtask

task automatic finish_test(input string name);
  tests++;
  if (errors == err_mark) $display("test %0d %s: ok", tests, name);
  else $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
  err_mark = errors;
endtask

// mode 0, msb first, one cs frame per byte
task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
  int i;
  @(posedge clk);
  cs <= 1'b0;
  for (i = 7; i >= 0; i--) begin
    mosi <= tx[i];
    repeat (spi_half) @(negedge clk);
    rx[i] = miso;  // sampled ahead of the rising edge
    @(posedge clk);
    sck <= 1'b1;
    repeat (spi_half) @(posedge clk);
    sck <= 1'b0;
  end
  repeat (spi_half) @(posedge clk);
  cs <= 1'b1;
  repeat (spi_gap) @(posedge clk);
endtask

task automatic spi_cmd(input logic [7:0] op, input logic [7:0] param, input int nparam);
  logic [7:0] rx;
  spi_xfer(op, rx);
  if (nparam > 0) spi_xfer(param, rx);
endtask

task automatic wait_req();
  int n;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!esp_req && n < req_timeout);
  if (!esp_req) report_error("esp_req did not rise after the bus strobe");
  else begin
    check_bit("wait_out with esp_req", wait_out, 1'b1);
    check_bit("led wait", led[0], 1'b1);
    check_bit("led esp_sel", led[1], 1'b1);
  end
endtask

task automatic cpu_in(input logic [7:0] port, output logic [7:0] data);
  @(posedge clk);
  a    <= {8'h00, port};
  in_n <= 1'b0;
  wait_req();
  data = d_out;  // strobe still held here
endtask

task automatic cpu_out(input logic [7:0] port, input logic [7:0] data);
  @(posedge clk);
  a     <= {8'h00, port};
  d_in  <= data;
  out_n <= 1'b0;
  wait_req();
endtask

// starts on the first cycle with esp_req high, releases the strobes at the end
task automatic esp_ack();
  int cnt;
  cnt = 0;
  while (esp_req && cnt < 4 * req_len) begin
    cnt++;
    @(negedge clk);
  end
  check_byte("esp_req length", 8'(cnt), 8'(req_len));
  repeat (5) @(negedge clk);
  check_bit("wait_out before esp_done", wait_out, 1'b1);
  @(posedge clk);
  esp_done <= 1'b1;
  cnt = 0;
  while (wait_out && cnt < done_timeout) begin
    @(negedge clk);
    cnt++;
  end
  if (wait_out) report_error("WAIT did not fall after esp_done");
  @(posedge clk);
  esp_done <= 1'b0;
  in_n     <= 1'b1;
  out_n    <= 1'b1;
  repeat (4) @(negedge clk);
endtask

task automatic mem_read(input logic [15:0] addr, output logic [7:0] data);
  @(posedge clk);
  a    <= addr;
  rd_n <= 1'b0;
  repeat (access_max + 2) @(negedge clk);  // past the capture on access
  data = d_out;
  @(posedge clk);
  rd_n <= 1'b1;
  repeat (4) @(negedge clk);
endtask

task automatic wait_irq();
  int n;
  n = 0;
  while (!int_out && n < 2 * irq_len) begin
    @(negedge clk);
    n++;
  end
  if (!int_out) report_error("INT did not rise within two timer periods");
endtask

`endif

// ==== dv/tb_trs_io.sv ====
`timescale 1ns/1ns

module tb_trs_io;

  import trs_bus_pkg::*;
  import spi_cmd_pkg::*;

  localparam int irq_len      = 400;
  localparam int req_len      = 50;     // esp_req width in clk
  localparam int access_max   = 3;      // strobe edge to access pulse
  localparam int spi_half     = 8;
  localparam int spi_gap      = 20;
  localparam int req_timeout  = 8;
  localparam int done_timeout = 10;
  localparam logic [7:0] filler = 8'hFF;  // unknown opcode, parser stays idle
  localparam int xfer_budget  = 200;
  localparam int bus_budget   = 120;
  // 18 spi bytes, 5 esp bus cycles, 2 interrupt waits
  localparam int watchdog_cycles = 10 + 18 * xfer_budget + 5 * bus_budget
                                   + 2 * 2 * irq_len + 1000;

  logic        clk;
  logic        rst_n;
  logic [15:0] a;
  logic        rd_n, wr_n, in_n, out_n;
  logic [7:0]  d_in;
  logic [7:0]  d_out;
  logic        dbus_en, dbus_dir;
  logic        cs, sck, mosi, miso;
  esp_s_e      esp_s;
  logic        esp_req, esp_done;
  logic        int_out, wait_out;
  logic [3:0]  conf;
  logic [3:0]  led;
  logic        led_red, led_green, led_blue;

  integer seed;
  int     tests;
  int     checks;
  int     errors;
  int     err_mark;

  trs_io_top #(.irq_period(irq_len)) uut (
    .clk(clk), .rst_n(rst_n), .a(a), .rd_n(rd_n), .wr_n(wr_n), .in_n(in_n), .out_n(out_n),
    .d_in(d_in), .d_out(d_out), .dbus_en(dbus_en), .dbus_dir(dbus_dir),
    .cs(cs), .sck(sck), .mosi(mosi), .miso(miso), .esp_s(esp_s), .esp_req(esp_req),
    .esp_done(esp_done), .int_out(int_out), .wait_out(wait_out), .conf(conf), .led(led),
    .led_red(led_red), .led_green(led_green), .led_blue(led_blue)
  );

  `include "tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // replies come back one transfer later
  task automatic test_identity();
    logic [7:0] rx;
    logic [3:0] c;
    c = 4'($random(seed));
    @(posedge clk);
    conf <= c;
    spi_cmd(get_cookie, 8'h00, 0);
    spi_xfer(get_version, rx);
    check_byte("cookie reply", rx, 8'hAF);
    spi_xfer(get_config, rx);
    check_byte("version reply", rx, 8'h03);
    spi_xfer(filler, rx);
    check_byte("config reply", rx, {4'h0, ~c});
    finish_test("identity replies");
  endtask

  task automatic test_esp_read();
    logic [7:0] v;
    logic [7:0] got;
    v = 8'($random(seed));
    spi_cmd(dbus_write, v, 1);
    cpu_in(8'h1F, got);
    check_esp_s(esp_s, trs_io_in);
    check_bit("dbus_en", dbus_en, 1'b0);
    check_bit("dbus_dir", dbus_dir, 1'b0);
    check_byte("d_out", got, v);
    esp_ack();
    check_esp_s(esp_s, idle);
    finish_test("port 1Fh read");
  endtask

  task automatic test_frehd_out();
    spi_cmd(spi_cmd_pkg::data_ready, 8'h00, 0);
    @(negedge clk);
    check_bit("led data_ready set", led[2], 1'b1);
    cpu_out(8'hC5, 8'($random(seed)));
    check_esp_s(esp_s, frehd_out);
    esp_ack();
    check_bit("led data_ready after C5h", led[2], 1'b1);  // FreHD leaves it alone
    cpu_out(8'h1F, 8'($random(seed)));
    check_esp_s(esp_s, trs_io_out);
    esp_ack();
    check_bit("led data_ready after 1Fh", led[2], 1'b0);
    finish_test("FreHD write");
  endtask

  task automatic test_leds();
    logic [7:0] lp;
    logic [7:0] sp;
    logic [7:0] rx;
    lp = 8'($random(seed));
    sp = 8'($random(seed));
    spi_cmd(set_led, lp, 1);
    spi_cmd(set_esp_status, sp, 1);
    @(negedge clk);
    check_leds(lp, sp);
    spi_cmd(get_cookie, 8'h00, 0);
    spi_xfer(8'h7E, rx);
    check_byte("reply before unknown opcode", rx, 8'hAF);
    spi_xfer(filler, rx);
    check_byte("reply after unknown opcode", rx, 8'hAF);
    @(negedge clk);
    check_leds(lp, sp);
    finish_test("led and esp status");
  endtask

  task automatic test_irq_status();
    logic [7:0] got;
    wait_irq();
    mem_read(16'h37E0, got);
    check_byte("irq status", got, 8'hA0);
    check_bit("int_out after read", int_out, 1'b0);
    spi_cmd(spi_cmd_pkg::data_ready, 8'h00, 0);
    wait_irq();
    mem_read(16'h37E2, got);
    check_byte("irq status with data ready", got, 8'h80);
    check_bit("int_out after read", int_out, 1'b0);
    finish_test("interrupt status");
  endtask

  task automatic test_bus_reads();
    logic [7:0]  dv;
    logic [15:0] av;
    logic [7:0]  rx;
    dv = 8'($random(seed));
    av = 16'($random(seed));
    @(posedge clk);
    d_in <= dv;
    spi_cmd(dbus_read, 8'h00, 0);
    d_in <= ~dv;  // reply must come from the latched value
    a    <= av;
    spi_xfer(abus_read, rx);
    check_byte("dbus_read reply", rx, dv);
    a <= ~av;
    spi_xfer(filler, rx);
    check_byte("abus_read reply", rx, av[7:0]);
    finish_test("bus reads");
  endtask

  initial begin
    seed     = 21;
    tests    = 0;
    checks   = 0;
    errors   = 0;
    err_mark = 0;
    rst_n    <= 1'b0;
    a        <= '0;
    rd_n     <= 1'b1;
    wr_n     <= 1'b1;
    in_n     <= 1'b1;
    out_n    <= 1'b1;
    d_in     <= '0;
    cs       <= 1'b1;
    sck      <= 1'b0;
    mosi     <= 1'b0;
    esp_done <= 1'b0;
    conf     <= '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);
    test_identity();
    test_esp_read();
    test_frehd_out();
    test_leds();
    test_irq_status();
    test_bus_reads();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+dv
rtl/spi_cmd_pkg.sv
rtl/trs_bus_pkg.sv
rtl/spi_byte_link.sv
rtl/trs_port_decoder.sv
rtl/cmd_parser.sv
rtl/cmd_exec.sv
rtl/esp_handshake.sv
rtl/bus_responder.sv
rtl/trs_io_top.sv
dv/tb_trs_io.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_trs_io -Mdir obj_dir

sim_out="$(./obj_dir/Vtb_trs_io)"
echo "$sim_out"

if grep -qx "Testbench passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
